/* source/dma_pkg.sv */
package dma_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Address bit 12 selects the scratch memory window
    localparam int MEM_WIN_BIT = 12;

    // Word offsets of the registers
    typedef enum logic [2:0] {
        REG_SRC    = 3'd0,
        REG_DST    = 3'd1,
        REG_QTY    = 3'd2,
        REG_CTRL   = 3'd3,
        REG_STATUS = 3'd4
    } reg_addr_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WDATA,
        S_BRESP,
        S_RDATA
    } slave_state_e;

    typedef enum logic [1:0] {
        E_IDLE,
        E_COPY,
        E_DRAIN
    } engine_state_e;

endpackage

/* source/mem_port_if.sv */
interface mem_port_if #(
    parameter int MEM_AW = 10
);
    import dma_pkg::*;

    logic              en;
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;
    // Valid the cycle after a read
    logic [DATA_W-1:0] rdata;

    modport master (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* source/scratch_mem.sv */
module scratch_mem #(
    parameter int MEM_AW = 10
) (
    input logic       clk,
    mem_port_if.slave port_a,
    mem_port_if.slave port_b
);
    import dma_pkg::*;

    localparam int DEPTH = 2 ** MEM_AW;

    logic [DATA_W-1:0] mem [DEPTH];

    // rdata only changes on a read, so it holds while the bus stalls
    always_ff @(posedge clk) begin
        if (port_a.en) begin
            if (port_a.we) begin
                mem[port_a.addr] <= port_a.wdata;
            end else begin
                port_a.rdata <= mem[port_a.addr];
            end
        end
        // Port B last so it wins a same-word write
        if (port_b.en) begin
            if (port_b.we) begin
                mem[port_b.addr] <= port_b.wdata;
            end else begin
                port_b.rdata <= mem[port_b.addr];
            end
        end
    end

endmodule

/* source/dma_engine.sv */
module dma_engine #(
    parameter int MEM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic [MEM_AW-1:0] src_i,
    input  logic [MEM_AW-1:0] dst_i,
    input  logic [MEM_AW:0]   qty_i,
    output logic              busy_o,
    output logic              fin_o,
    mem_port_if.master        mem_b
);
    import dma_pkg::*;

    engine_state_e state;

    logic [MEM_AW-1:0] src_r;
    logic [MEM_AW-1:0] dst_r;
    logic [MEM_AW:0]   qty_r;
    logic [MEM_AW:0]   rd_cnt;
    logic [MEM_AW:0]   wr_cnt;
    logic [MEM_AW-1:0] wr_addr_r;
    // High in the cycle that writes the word read just before
    logic              wr_ph;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= E_IDLE;
            src_r     <= '0;
            dst_r     <= '0;
            qty_r     <= '0;
            rd_cnt    <= '0;
            wr_cnt    <= '0;
            wr_addr_r <= '0;
            wr_ph     <= 1'b0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (start_i) begin
                        src_r  <= src_i;
                        dst_r  <= dst_i;
                        qty_r  <= qty_i;
                        rd_cnt <= '0;
                        wr_cnt <= '0;
                        wr_ph  <= 1'b0;
                        state  <= (qty_i == '0) ? E_DRAIN : E_COPY;
                    end
                end
                E_COPY: begin
                    if (!wr_ph) begin
                        rd_cnt    <= rd_cnt + 1'b1;
                        wr_addr_r <= dst_r + rd_cnt[MEM_AW-1:0];
                        wr_ph     <= 1'b1;
                    end else begin
                        wr_cnt <= wr_cnt + 1'b1;
                        wr_ph  <= 1'b0;
                        if (wr_cnt + 1'b1 == qty_r) begin
                            state <= E_DRAIN;
                        end
                    end
                end
                E_DRAIN: state <= E_IDLE;
                default: state <= E_IDLE;
            endcase
        end
    end

    // Read source word, then write it back out on the next cycle
    assign mem_b.en    = (state == E_COPY);
    assign mem_b.we    = (state == E_COPY) & wr_ph;
    assign mem_b.addr  = wr_ph ? wr_addr_r : src_r + rd_cnt[MEM_AW-1:0];
    assign mem_b.wdata = mem_b.rdata;

    assign busy_o = (state != E_IDLE);
    assign fin_o  = (state == E_DRAIN);

endmodule

/* source/dma_regs.sv */
module dma_regs #(
    parameter int MEM_AW = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    // Write address
    input  logic [dma_pkg::ID_W-1:0]    awid_i,
    input  logic [dma_pkg::ADDR_W-1:0]  awaddr_i,
    input  logic [dma_pkg::LEN_W-1:0]   awlen_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    // Write data
    input  logic [dma_pkg::DATA_W-1:0]  wdata_i,
    input  logic [dma_pkg::DATA_W/8-1:0] wstrb_i,
    input  logic                        wlast_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    // Write response
    output logic [dma_pkg::ID_W-1:0]    bid_o,
    output logic [1:0]                  bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    // Read address
    input  logic [dma_pkg::ID_W-1:0]    arid_i,
    input  logic [dma_pkg::ADDR_W-1:0]  araddr_i,
    input  logic [dma_pkg::LEN_W-1:0]   arlen_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    // Read data
    output logic [dma_pkg::ID_W-1:0]    rid_o,
    output logic [dma_pkg::DATA_W-1:0]  rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rlast_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    // Scratch memory window
    mem_port_if.master                  mem_a,
    // Engine control
    output logic                        start_o,
    output logic [MEM_AW-1:0]           src_o,
    output logic [MEM_AW-1:0]           dst_o,
    output logic [MEM_AW:0]             qty_o,
    input  logic                        busy_i,
    input  logic                        fin_i,
    output logic                        irq_o
);
    import dma_pkg::*;

    slave_state_e state, next;

    logic awhns, whns, arhns;
    logic accept;

    logic [MEM_WIN_BIT:2] addr_r;
    logic [MEM_WIN_BIT:2] wr_addr;
    logic                 wr_win;
    logic                 ar_win;
    logic                 rwin_r;
    reg_addr_e            wr_reg;
    reg_addr_e            ar_reg;

    logic [ID_W-1:0]   id_r;
    logic [DATA_W-1:0] reg_rdata;
    logic [DATA_W-1:0] rdata_r;
    logic              done_r;

    assign awhns = awvalid_i & awready_o;
    assign whns  = wvalid_i  & wready_o;
    assign arhns = arvalid_i & arready_o;

    // A new request may be taken while the previous response completes
    assign accept = (state == S_IDLE) | (state == S_BRESP & bready_i) |
                    (state == S_RDATA & rready_i);

    assign awready_o = accept;
    assign arready_o = accept & ~awvalid_i;
    assign wready_o  = (state == S_WDATA) | (accept & awvalid_i);
    assign bvalid_o  = (state == S_BRESP);
    assign rvalid_o  = (state == S_RDATA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            S_IDLE, S_BRESP, S_RDATA: begin
                if (accept) begin
                    if (awhns && whns) begin
                        next = S_BRESP;
                    end else if (awhns) begin
                        next = S_WDATA;
                    end else if (arhns) begin
                        next = S_RDATA;
                    end else begin
                        next = S_IDLE;
                    end
                end
            end
            S_WDATA: begin
                if (whns) begin
                    next = S_BRESP;
                end
            end
            default: next = S_IDLE;
        endcase
    end

    // W may arrive with AW, so take the live address then
    assign wr_addr = (state == S_WDATA) ? addr_r : awaddr_i[MEM_WIN_BIT:2];
    assign wr_win  = wr_addr[MEM_WIN_BIT];
    assign wr_reg  = reg_addr_e'(wr_addr[4:2]);
    assign ar_win  = araddr_i[MEM_WIN_BIT];
    assign ar_reg  = reg_addr_e'(araddr_i[4:2]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_r  <= '0;
            id_r    <= '0;
            rdata_r <= '0;
            rwin_r  <= 1'b0;
        end else begin
            if (awhns) begin
                addr_r <= awaddr_i[MEM_WIN_BIT:2];
                id_r   <= awid_i;
            end else if (arhns) begin
                id_r    <= arid_i;
                rdata_r <= reg_rdata;
                rwin_r  <= ar_win;
            end
        end
    end

    // Memory window accesses go straight to port A
    assign mem_a.en    = (arhns & ar_win) | (whns & wr_win);
    assign mem_a.we    = whns & wr_win;
    assign mem_a.addr  = arhns ? araddr_i[MEM_AW+1:2] : wr_addr[MEM_AW+1:2];
    assign mem_a.wdata = wdata_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_o   <= '0;
            dst_o   <= '0;
            qty_o   <= '0;
            start_o <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (fin_i) begin
                done_r <= 1'b1;
            end
            if (whns && !wr_win) begin
                case (wr_reg)
                    REG_SRC:  src_o   <= wdata_i[MEM_AW-1:0];
                    REG_DST:  dst_o   <= wdata_i[MEM_AW-1:0];
                    REG_QTY:  qty_o   <= wdata_i[MEM_AW:0];
                    REG_CTRL: start_o <= wdata_i[0];
                    REG_STATUS: begin
                        // A finishing copy in the same cycle keeps done set
                        if (wdata_i[1] && !fin_i) begin
                            done_r <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (ar_reg)
            REG_SRC:    reg_rdata = DATA_W'(src_o);
            REG_DST:    reg_rdata = DATA_W'(dst_o);
            REG_QTY:    reg_rdata = DATA_W'(qty_o);
            REG_STATUS: reg_rdata = DATA_W'({done_r, busy_i});
            default:    reg_rdata = '0;
        endcase
    end

    assign rdata_o = rwin_r ? mem_a.rdata : rdata_r;
    assign rid_o   = id_r;
    assign bid_o   = id_r;
    assign rresp_o = RESP_OKAY;
    assign bresp_o = RESP_OKAY;
    assign rlast_o = 1'b1;
    assign irq_o   = done_r;

endmodule

/* source/dma_top.sv */
module dma_top #(
    parameter int MEM_AW = 10
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [dma_pkg::ID_W-1:0]     awid_i,
    input  logic [dma_pkg::ADDR_W-1:0]   awaddr_i,
    input  logic [dma_pkg::LEN_W-1:0]    awlen_i,
    input  logic                         awvalid_i,
    output logic                         awready_o,
    input  logic [dma_pkg::DATA_W-1:0]   wdata_i,
    input  logic [dma_pkg::DATA_W/8-1:0] wstrb_i,
    input  logic                         wlast_i,
    input  logic                         wvalid_i,
    output logic                         wready_o,
    output logic [dma_pkg::ID_W-1:0]     bid_o,
    output logic [1:0]                   bresp_o,
    output logic                         bvalid_o,
    input  logic                         bready_i,
    input  logic [dma_pkg::ID_W-1:0]     arid_i,
    input  logic [dma_pkg::ADDR_W-1:0]   araddr_i,
    input  logic [dma_pkg::LEN_W-1:0]    arlen_i,
    input  logic                         arvalid_i,
    output logic                         arready_o,
    output logic [dma_pkg::ID_W-1:0]     rid_o,
    output logic [dma_pkg::DATA_W-1:0]   rdata_o,
    output logic [1:0]                   rresp_o,
    output logic                         rlast_o,
    output logic                         rvalid_o,
    input  logic                         rready_i,
    output logic                         irq_o
);

    logic              start;
    logic [MEM_AW-1:0] src;
    logic [MEM_AW-1:0] dst;
    logic [MEM_AW:0]   qty;
    logic              busy;
    logic              fin;

    // Host side and engine side of the scratch memory
    mem_port_if #(.MEM_AW(MEM_AW)) port_a ();
    mem_port_if #(.MEM_AW(MEM_AW)) port_b ();

    dma_regs #(
        .MEM_AW(MEM_AW)
    ) u_dma_regs (
        .clk       (clk),
        .rst       (rst),
        .awid_i    (awid_i),
        .awaddr_i  (awaddr_i),
        .awlen_i   (awlen_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wlast_i   (wlast_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .arid_i    (arid_i),
        .araddr_i  (araddr_i),
        .arlen_i   (arlen_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rlast_o   (rlast_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .mem_a     (port_a.master),
        .start_o   (start),
        .src_o     (src),
        .dst_o     (dst),
        .qty_o     (qty),
        .busy_i    (busy),
        .fin_i     (fin),
        .irq_o     (irq_o)
    );

    dma_engine #(
        .MEM_AW(MEM_AW)
    ) u_dma_engine (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .src_i   (src),
        .dst_i   (dst),
        .qty_i   (qty),
        .busy_o  (busy),
        .fin_o   (fin),
        .mem_b   (port_b.master)
    );

    scratch_mem #(
        .MEM_AW(MEM_AW)
    ) u_scratch_mem (
        .clk    (clk),
        .port_a (port_a.slave),
        .port_b (port_b.slave)
    );

endmodule

/* tb/tb_dma_top.sv */
module tb_dma_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_AW     = 8;
    localparam int WORDS      = 2 ** MEM_AW;
    localparam int NCOPY      = 3;
    localparam int WAIT_LIMIT = 64;
    // Bound per access, full-memory passes, copies, then margin
    localparam int RUN_CYC    = WORDS * (NCOPY + 4) * 12 + 64 * 12 +
                                (NCOPY + 2) * (2 * 64 + 10) + 2000;
    localparam int TIMEOUT_NS = RUN_CYC * 20;

    logic        clk;
    logic        rst;
    logic [3:0]  awid_i;
    logic [31:0] awaddr_i;
    logic [7:0]  awlen_i;
    logic        awvalid_i;
    logic        awready_o;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic        wlast_i;
    logic        wvalid_i;
    logic        wready_o;
    logic [3:0]  bid_o;
    logic [1:0]  bresp_o;
    logic        bvalid_o;
    logic        bready_i;
    logic [3:0]  arid_i;
    logic [31:0] araddr_i;
    logic [7:0]  arlen_i;
    logic        arvalid_i;
    logic        arready_o;
    logic [3:0]  rid_o;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        rlast_o;
    logic        rvalid_o;
    logic        rready_i;
    logic        irq_o;

    int          errors;
    logic [31:0] shadow [WORDS];

    dma_top #(
        .MEM_AW(MEM_AW)
    ) u_dma_top (
        .clk(clk), .rst(rst),
        .awid_i(awid_i), .awaddr_i(awaddr_i), .awlen_i(awlen_i),
        .awvalid_i(awvalid_i), .awready_o(awready_o),
        .wdata_i(wdata_i), .wstrb_i(wstrb_i), .wlast_i(wlast_i),
        .wvalid_i(wvalid_i), .wready_o(wready_o),
        .bid_o(bid_o), .bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
        .arid_i(arid_i), .araddr_i(araddr_i), .arlen_i(arlen_i),
        .arvalid_i(arvalid_i), .arready_o(arready_o),
        .rid_o(rid_o), .rdata_o(rdata_o), .rresp_o(rresp_o), .rlast_o(rlast_o),
        .rvalid_o(rvalid_o), .rready_i(rready_i),
        .irq_o(irq_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        #TIMEOUT_NS;
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    function automatic logic [31:0] mem_addr(input int w);
        return 32'h1000 | (32'(MEM_AW'(w)) << 2);
    endfunction

    // Expected memory after a copy, one word after the other
    function automatic void copy_ref(input int src, input int dst, input int qty);
        for (int k = 0; k < qty; k++) begin
            shadow[MEM_AW'(dst + k)] = shadow[MEM_AW'(src + k)];
        end
    endfunction

    // All waits below sample 1 ns after the falling edge where signals are stable
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input bit same, input int hold_max);
        logic [3:0] id;
        int         n;
        id = 4'($urandom);
        @(negedge clk);
        awid_i    = id;
        awaddr_i  = addr;
        awvalid_i = 1'b1;
        if (same) begin
            wdata_i  = data;
            wvalid_i = 1'b1;
        end
        #1;
        n = 0;
        while (!awready_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (awready_o) else report_error("awready_o never rose");
        if (same) begin
            assert (wready_o) else report_error("wready_o low while AW and W were offered together");
        end
        @(negedge clk);
        awvalid_i = 1'b0;
        if (!same) begin
            repeat ($urandom_range(2, 0)) @(negedge clk);
            wdata_i  = data;
            wvalid_i = 1'b1;
            #1;
            n = 0;
            while (!wready_o && n < WAIT_LIMIT) begin
                @(negedge clk);
                #1;
                n++;
            end
            assert (wready_o) else report_error("wready_o never rose");
            @(negedge clk);
        end
        wvalid_i = 1'b0;
        repeat ($urandom_range(hold_max, 0)) @(negedge clk);
        bready_i = 1'b1;
        #1;
        n = 0;
        while (!bvalid_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (bvalid_o) else report_error("no write response arrived");
        check_eq("bid_o", 32'(id), 32'(bid_o));
        check_eq("bresp_o", 32'd0, 32'(bresp_o));
        @(negedge clk);
        bready_i = 1'b0;
        #1;
        assert (!bvalid_o) else report_error("a second write response followed one request");
    endtask

    task automatic axi_read(input logic [31:0] addr, input int hold_max,
                            output logic [31:0] data);
        logic [3:0] id;
        int         n;
        id = 4'($urandom);
        @(negedge clk);
        arid_i    = id;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        #1;
        n = 0;
        while (!arready_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (arready_o) else report_error("arready_o never rose");
        @(negedge clk);
        arvalid_i = 1'b0;
        repeat ($urandom_range(hold_max, 0)) @(negedge clk);
        rready_i = 1'b1;
        #1;
        n = 0;
        while (!rvalid_o && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (rvalid_o) else report_error("no read response arrived");
        data = rdata_o;
        check_eq("rid_o", 32'(id), 32'(rid_o));
        check_eq("rresp_o", 32'd0, 32'(rresp_o));
        check_eq("rlast_o", 32'd1, 32'(rlast_o));
        @(negedge clk);
        rready_i = 1'b0;
        #1;
        assert (!rvalid_o) else report_error("a second read response followed one request");
    endtask

    task automatic compare_memory();
        logic [31:0] got;
        for (int w = 0; w < WORDS; w++) begin
            axi_read(mem_addr(w), 0, got);
            check_eq($sformatf("rdata_o word %0d", w), shadow[MEM_AW'(w)], got);
        end
    endtask

    task automatic run_copy(input int src, input int dst, input int qty);
        axi_write(32'h0, 32'(MEM_AW'(src)), 1'b1, 2);
        axi_write(32'h4, 32'(MEM_AW'(dst)), 1'b1, 2);
        axi_write(32'h8, 32'(qty), 1'b1, 2);
        axi_write(32'hC, 32'd1, 1'b1, 2);
    endtask

    task automatic wait_irq(input int max_cyc);
        int n;
        n = 0;
        while (!irq_o && n < max_cyc) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (irq_o) else report_error("irq_o did not rise at the end of a copy");
    endtask

    // Checks done, clears it and checks that irq_o falls
    task automatic finish_copy();
        logic [31:0] got;
        axi_read(32'h10, 1, got);
        check_eq("STATUS", 32'd2, got);
        axi_write(32'h10, 32'd2, 1'b1, 1);
        axi_read(32'h10, 1, got);
        check_eq("STATUS", 32'd0, got);
        check_eq("irq_o", 32'd0, 32'(irq_o));
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] d;
        int          src;
        int          dst;
        int          qty;
        int          w;
        errors = 0;
        void'($urandom(79));
        rst       = 1'b1;
        awid_i    = '0;
        awaddr_i  = '0;
        awlen_i   = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wstrb_i   = 4'hF;
        wlast_i   = 1'b1;
        wvalid_i  = 1'b0;
        bready_i  = 1'b0;
        arid_i    = '0;
        araddr_i  = '0;
        arlen_i   = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Load the whole memory through the window
        for (int i = 0; i < WORDS; i++) begin
            d = $urandom;
            shadow[MEM_AW'(i)] = d;
            axi_write(mem_addr(i), d, i[0], 3);
        end
        compare_memory();

        // Register readback
        axi_write(32'h0, 32'h5A, 1'b0, 4);
        axi_write(32'h4, 32'hC3, 1'b1, 4);
        axi_write(32'h8, 32'h1F0, 1'b0, 4);
        axi_read(32'h0, 4, got);
        check_eq("SRC", 32'h5A, got);
        axi_read(32'h4, 4, got);
        check_eq("DST", 32'hC3, got);
        axi_read(32'h8, 4, got);
        check_eq("QTY", 32'h1F0, got);

        // Copies that do not overlap
        for (int c = 0; c < NCOPY; c++) begin
            qty = 1 + int'($urandom_range(63, 0));
            src = int'($urandom_range(WORDS - 1, 0));
            dst = src + qty + int'($urandom_range(WORDS - 2 * qty, 0));
            run_copy(src, dst, qty);
            wait_irq(2 * qty + 20);
            finish_copy();
            copy_ref(src, dst, qty);
            compare_memory();
        end

        run_copy(10, 100, 0);
        wait_irq(20);
        finish_copy();
        compare_memory();

        // Second start while busy must be ignored
        run_copy(0, 128, 64);
        axi_read(32'h10, 0, got);
        check_eq("STATUS busy", 32'd1, got & 32'd1);
        axi_write(32'h4, 32'd64, 1'b1, 0);
        axi_write(32'hC, 32'd1, 1'b1, 0);
        wait_irq(2 * 64 + 20);
        finish_copy();
        repeat (2 * 64 + 10) @(negedge clk);
        assert (!irq_o) else report_error("a start while busy launched a second copy");
        copy_ref(0, 128, 64);
        compare_memory();

        // Long back-pressure, both AW/W orderings
        for (int i = 0; i < 16; i++) begin
            w = int'($urandom_range(WORDS - 1, 0));
            d = $urandom;
            shadow[MEM_AW'(w)] = d;
            axi_write(mem_addr(w), d, i[0], 12);
            axi_read(mem_addr(w), 12, got);
            check_eq($sformatf("rdata_o word %0d", w), d, got);
        end
        axi_write(32'h0, 32'h21, 1'b0, 12);
        axi_read(32'h0, 12, got);
        check_eq("SRC", 32'h21, got);
        compare_memory();

        $display("Checks failed: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
source/dma_pkg.sv
source/mem_port_if.sv
source/scratch_mem.sv
source/dma_engine.sv
source/dma_regs.sv
source/dma_top.sv
tb/tb_dma_top.sv

/* Makefile */
TOOL     = verilator
TOP      = tb_dma_top
FILELIST = compile.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP)
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJDIR)
